// ==== design/clic_defines.svh ====
// CLIC configuration macros
`ifndef CLIC_DEFINES_SVH
`define CLIC_DEFINES_SVH

//==========================================================================
// Interrupt sizing
//==========================================================================

// Number of interrupt sources
`define CLIC_INT_NUM 8

// Id width, log2 of the source count
`define CLIC_ID_W 3

//==========================================================================
// Register base addresses
//==========================================================================

// Global control registers, exact-match decode
`define CLICCFG_BASE    16'h0000
`define CLICINFO_BASE   16'h0004
`define MINTTHRESH_BASE 16'h0008

// Per-interrupt words start here, one word per id
`define CLICKID_BASE    16'h1000

`endif

// ==== design/clic_bus_pkg.sv ====
// CLIC register bus types
`default_nettype none

package clic_bus_pkg;

  // Bus address, 64 KB window
  typedef logic [15:0] clic_addr_t;

  // Bus data word
  typedef logic [31:0] clic_data_t;

  // Access size
  // 0 byte, 1 half-word, 2 word
  typedef logic [1:0] clic_size_t;

  // Request, single-cycle strobe
  typedef struct packed {
    logic       sel;
    logic       write;
    clic_size_t size;
    clic_addr_t addr;
    clic_data_t wdata;
  } clic_bus_req_t;

  // Response, same cycle as the strobe
  typedef struct packed {
    logic       cmplt;
    clic_data_t rdata;
  } clic_bus_rsp_t;

endpackage

`default_nettype wire

// ==== design/clic_int_pkg.sv ====
// CLIC interrupt types
`default_nettype none

`include "clic_defines.svh"

package clic_int_pkg;

  // Interrupt level, wider is more urgent
  typedef logic [7:0] clic_ctl_t;

  // Interrupt id
  typedef logic [`CLIC_ID_W-1:0] clic_id_t;

  // Byte-register selects, one bit per interrupt
  typedef struct packed {
    logic [`CLIC_INT_NUM-1:0] ip;
    logic [`CLIC_INT_NUM-1:0] ie;
    logic [`CLIC_INT_NUM-1:0] attr;
    logic [`CLIC_INT_NUM-1:0] ctl;
  } clic_kid_sel_t;

  // Request presented to the core
  typedef struct packed {
    logic      vld;
    clic_id_t  id;
    clic_ctl_t ctl;
  } clic_int_req_t;

endpackage

`default_nettype wire

// ==== design/clic_sel.sv ====
// One-hot word multiplexer
`timescale 1ns/1ps
`default_nettype none

module clic_sel #(
  parameter int WIDTH = 8,
  parameter int NUM   = 4
) (
  input  wire logic [WIDTH*NUM-1:0] data_in,
  input  wire logic [NUM-1:0]       sel_onehot,
  output logic      [WIDTH-1:0]     data_out
);

  // AND-OR tree
  // No select bit set gives zero
  always_comb
  begin
    data_out = '0;
    for (int i = 0; i < NUM; i++)
    begin
      data_out = data_out | (data_in[i*WIDTH +: WIDTH] & {WIDTH{sel_onehot[i]}});
    end
  end

endmodule

`default_nettype wire

// ==== design/clic_busif.sv ====
// CLIC bus interface
`timescale 1ns/1ps
`default_nettype none

`include "clic_defines.svh"

module clic_busif
  import clic_bus_pkg::*;
  import clic_int_pkg::*;
(
  input  wire clic_bus_req_t                        bus_req,
  output clic_bus_rsp_t                             bus_rsp,
  output logic                                      cfg_sel,
  output logic                                      info_sel,
  output logic                                      thresh_sel,
  output logic                                      write_vld,
  output clic_data_t                                wdata,
  output clic_kid_sel_t                             kid_sel,
  input  wire clic_data_t                           cfg_val,
  input  wire clic_data_t                           info_val,
  input  wire clic_data_t                           thresh_val,
  input  wire logic [`CLIC_INT_NUM*32-1:0]          kid_rdata_vec
);

  localparam clic_addr_t KID_BASE = `CLICKID_BASE;

  logic                     read_vld;
  clic_addr_t               kid_off;
  logic [3:0]               lane_mask;
  logic [`CLIC_INT_NUM-1:0] kid_hit;
  clic_data_t               kid_rdata;

  //==========================================================================
  // Control register decode
  //==========================================================================

  // Exact address, any size
  assign cfg_sel    = (bus_req.addr == `CLICCFG_BASE);
  assign info_sel   = (bus_req.addr == `CLICINFO_BASE);
  assign thresh_sel = (bus_req.addr == `MINTTHRESH_BASE);

  // Strobe qualified by direction
  assign write_vld = bus_req.sel & bus_req.write;
  assign read_vld  = bus_req.sel & ~bus_req.write;
  assign wdata     = bus_req.wdata;

  //==========================================================================
  // Per-interrupt decode
  //==========================================================================

  // Lane mask from offset and size
  // Misaligned half-word or word selects nothing
  always_comb
  begin
    case ({bus_req.addr[1:0], bus_req.size})
      4'b00_00: lane_mask = 4'b0001;
      4'b01_00: lane_mask = 4'b0010;
      4'b10_00: lane_mask = 4'b0100;
      4'b11_00: lane_mask = 4'b1000;
      4'b00_01: lane_mask = 4'b0011;
      4'b10_01: lane_mask = 4'b1100;
      4'b00_10: lane_mask = 4'b1111;
      default:  lane_mask = 4'b0000;
    endcase
  end

  // Offset into the interrupt word array
  assign kid_off = bus_req.addr - KID_BASE;

  for (genvar i = 0; i < `CLIC_INT_NUM; i++)
  begin : g_kid
    // Word index match, lanes pick ip/ie/attr/ctl
    assign kid_hit[i]      = (kid_off[15:2] == 14'(i));
    assign kid_sel.ip[i]   = kid_hit[i] & lane_mask[0];
    assign kid_sel.ie[i]   = kid_hit[i] & lane_mask[1];
    assign kid_sel.attr[i] = kid_hit[i] & lane_mask[2];
    assign kid_sel.ctl[i]  = kid_hit[i] & lane_mask[3];
  end

  //==========================================================================
  // Read data merge
  //==========================================================================

  clic_sel #(
    .WIDTH (32),
    .NUM   (`CLIC_INT_NUM)
  ) u_kid_rdata_sel (
    .data_in    (kid_rdata_vec),
    .sel_onehot (kid_hit),
    .data_out   (kid_rdata)
  );

  // Done in the strobe cycle, no wait states
  assign bus_rsp.cmplt = bus_req.sel;

  // Zero outside a read
  assign bus_rsp.rdata = ((cfg_val    & {32{cfg_sel}})
                        | (info_val   & {32{info_sel}})
                        | (thresh_val & {32{thresh_sel}})
                        | (kid_rdata  & {32{|kid_hit}}))
                        & {32{read_vld}};

endmodule

`default_nettype wire

// ==== design/clic_ctrl.sv ====
// CLIC global control registers
`timescale 1ns/1ps
`default_nettype none

`include "clic_defines.svh"

module clic_ctrl
  import clic_bus_pkg::*;
  import clic_int_pkg::*;
(
  input  wire logic       clic_clk,
  input  wire logic       rst_n,
  input  wire logic       cfg_sel,
  input  wire logic       info_sel,
  input  wire logic       thresh_sel,
  input  wire logic       write_vld,
  input  wire clic_data_t wdata,
  output clic_data_t      cfg_val,
  output clic_data_t      info_val,
  output clic_data_t      thresh_val,
  output clic_ctl_t       mintthresh
);

  logic [3:0] nlbits_q;
  clic_ctl_t  thresh_q;
  clic_data_t info_word;

  // cliccfg nlbits, stored only
  always_ff @(posedge clic_clk or negedge rst_n)
  begin
    if (!rst_n)
      nlbits_q <= '0;
    else if (write_vld && cfg_sel)
      nlbits_q <= wdata[4:1];
  end

  // mintthresh, full byte
  always_ff @(posedge clic_clk or negedge rst_n)
  begin
    if (!rst_n)
      thresh_q <= '0;
    else if (write_vld && thresh_sel)
      thresh_q <= wdata[7:0];
  end

  // clicinfo is constant, writes dropped
  assign info_word = {19'd0, 13'(`CLIC_INT_NUM)};

  // Read words, zero padded
  // Driven only while addressed
  assign cfg_val    = {27'd0, nlbits_q, 1'b0} & {32{cfg_sel}};
  assign info_val   = info_word & {32{info_sel}};
  assign thresh_val = {24'd0, thresh_q} & {32{thresh_sel}};

  // Threshold to the arbiter
  assign mintthresh = thresh_q;

endmodule

`default_nettype wire

// ==== design/clic_kid.sv ====
// CLIC per-interrupt registers
`timescale 1ns/1ps
`default_nettype none

`include "clic_defines.svh"

module clic_kid
  import clic_bus_pkg::*;
  import clic_int_pkg::*;
(
  input  wire logic                               clic_clk,
  input  wire logic                               rst_n,
  input  wire logic [`CLIC_INT_NUM-1:0]           int_src,
  input  wire clic_kid_sel_t                      kid_sel,
  input  wire logic                               write_vld,
  input  wire clic_data_t                         wdata,
  output logic      [`CLIC_INT_NUM*32-1:0]        kid_rdata_vec,
  output logic      [`CLIC_INT_NUM-1:0]           int_ip,
  output logic      [`CLIC_INT_NUM-1:0]           int_ie,
  output clic_ctl_t [`CLIC_INT_NUM-1:0]           int_ctl
);

  logic      [`CLIC_INT_NUM-1:0] ip_q;
  logic      [`CLIC_INT_NUM-1:0] ie_q;
  logic      [`CLIC_INT_NUM-1:0] attr_q;
  logic      [`CLIC_INT_NUM-1:0] src_q;
  clic_ctl_t [`CLIC_INT_NUM-1:0] ctl_q;

  //==========================================================================
  // Register array
  //==========================================================================

  always_ff @(posedge clic_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ip_q   <= '0;
      ie_q   <= '0;
      attr_q <= '0;
      src_q  <= '0;
      ctl_q  <= '0;
    end
    else
    begin
      // Previous source level for edge detect
      src_q <= int_src;
      for (int i = 0; i < `CLIC_INT_NUM; i++)
      begin
        // Level mode tracks the source, bus writes ignored
        if (!attr_q[i])
          ip_q[i] <= int_src[i];
        // Edge mode, a rise beats a same-cycle write
        else if (int_src[i] && !src_q[i])
          ip_q[i] <= 1'b1;
        else if (write_vld && kid_sel.ip[i])
          ip_q[i] <= wdata[0];

        // Lane k takes wdata byte k
        if (write_vld && kid_sel.ie[i])
          ie_q[i] <= wdata[8];
        if (write_vld && kid_sel.attr[i])
          attr_q[i] <= wdata[16];
        if (write_vld && kid_sel.ctl[i])
          ctl_q[i] <= wdata[31:24];
      end
    end
  end

  //==========================================================================
  // Readback and arbiter view
  //==========================================================================

  // {ctl, attr, ie, ip}, unused bits zero
  for (genvar i = 0; i < `CLIC_INT_NUM; i++)
  begin : g_rdata
    assign kid_rdata_vec[i*32 +: 32] = {ctl_q[i], 7'd0, attr_q[i], 7'd0, ie_q[i], 7'd0, ip_q[i]};
  end

  assign int_ip  = ip_q;
  assign int_ie  = ie_q;
  assign int_ctl = ctl_q;

endmodule

`default_nettype wire

// ==== design/clic_arb.sv ====
// CLIC interrupt arbiter
`timescale 1ns/1ps
`default_nettype none

`include "clic_defines.svh"

module clic_arb
  import clic_int_pkg::*;
(
  input  wire logic                          clic_clk,
  input  wire logic                          rst_n,
  input  wire logic      [`CLIC_INT_NUM-1:0] int_ip,
  input  wire logic      [`CLIC_INT_NUM-1:0] int_ie,
  input  wire clic_ctl_t [`CLIC_INT_NUM-1:0] int_ctl,
  input  wire clic_ctl_t                     mintthresh,
  output clic_int_req_t                      int_req
);

  logic [`CLIC_INT_NUM-1:0] elig;
  logic                     found;
  clic_id_t                 best_id;
  clic_ctl_t                best_ctl;

  // Pending, enabled, above threshold
  always_comb
  begin
    for (int i = 0; i < `CLIC_INT_NUM; i++)
    begin
      elig[i] = int_ip[i] & int_ie[i] & (int_ctl[i] > mintthresh);
    end
  end

  //==========================================================================
  // Highest level wins
  //==========================================================================

  // Strict compare keeps the lower id on a tie
  always_comb
  begin
    found    = 1'b0;
    best_id  = '0;
    best_ctl = '0;
    for (int i = 0; i < `CLIC_INT_NUM; i++)
    begin
      if (elig[i] && (!found || (int_ctl[i] > best_ctl)))
      begin
        found    = 1'b1;
        best_id  = clic_id_t'(i);
        best_ctl = int_ctl[i];
      end
    end
  end

  // Registered request, id and ctl zero when idle
  always_ff @(posedge clic_clk or negedge rst_n)
  begin
    if (!rst_n)
      int_req <= '0;
    else
    begin
      int_req.vld <= found;
      int_req.id  <= best_id;
      int_req.ctl <= best_ctl;
    end
  end

endmodule

`default_nettype wire

// ==== design/clic_top.sv ====
// CLIC top level
`timescale 1ns/1ps
`default_nettype none

`include "clic_defines.svh"

module clic_top
  import clic_bus_pkg::*;
  import clic_int_pkg::*;
(
  input  wire logic                     clic_clk,
  input  wire logic                     rst_n,
  input  wire clic_bus_req_t            bus_req,
  output clic_bus_rsp_t                 bus_rsp,
  input  wire logic [`CLIC_INT_NUM-1:0] int_src,
  output clic_int_req_t                 int_req
);

  // Bus interface to register blocks
  logic          cfg_sel;
  logic          info_sel;
  logic          thresh_sel;
  logic          write_vld;
  clic_data_t    wdata;
  clic_kid_sel_t kid_sel;

  // Readback
  clic_data_t                  cfg_val;
  clic_data_t                  info_val;
  clic_data_t                  thresh_val;
  logic [`CLIC_INT_NUM*32-1:0] kid_rdata_vec;

  // Register state to arbiter
  logic      [`CLIC_INT_NUM-1:0] int_ip;
  logic      [`CLIC_INT_NUM-1:0] int_ie;
  clic_ctl_t [`CLIC_INT_NUM-1:0] int_ctl;
  clic_ctl_t                     mintthresh;

  clic_busif u_busif (
    .bus_req       (bus_req),
    .bus_rsp       (bus_rsp),
    .cfg_sel       (cfg_sel),
    .info_sel      (info_sel),
    .thresh_sel    (thresh_sel),
    .write_vld     (write_vld),
    .wdata         (wdata),
    .kid_sel       (kid_sel),
    .cfg_val       (cfg_val),
    .info_val      (info_val),
    .thresh_val    (thresh_val),
    .kid_rdata_vec (kid_rdata_vec)
  );

  clic_ctrl u_ctrl (
    .clic_clk   (clic_clk),
    .rst_n      (rst_n),
    .cfg_sel    (cfg_sel),
    .info_sel   (info_sel),
    .thresh_sel (thresh_sel),
    .write_vld  (write_vld),
    .wdata      (wdata),
    .cfg_val    (cfg_val),
    .info_val   (info_val),
    .thresh_val (thresh_val),
    .mintthresh (mintthresh)
  );

  clic_kid u_kid (
    .clic_clk      (clic_clk),
    .rst_n         (rst_n),
    .int_src       (int_src),
    .kid_sel       (kid_sel),
    .write_vld     (write_vld),
    .wdata         (wdata),
    .kid_rdata_vec (kid_rdata_vec),
    .int_ip        (int_ip),
    .int_ie        (int_ie),
    .int_ctl       (int_ctl)
  );

  clic_arb u_arb (
    .clic_clk   (clic_clk),
    .rst_n      (rst_n),
    .int_ip     (int_ip),
    .int_ie     (int_ie),
    .int_ctl    (int_ctl),
    .mintthresh (mintthresh),
    .int_req    (int_req)
  );

endmodule

`default_nettype wire

// ==== tb/clic_props.sv ====
// CLIC bus and request checks
`timescale 1ns/1ps
`default_nettype none

module clic_props
  import clic_bus_pkg::*;
  import clic_int_pkg::*;
(
  input wire logic          clic_clk,
  input wire logic          rst_n,
  input wire clic_bus_req_t bus_req,
  input wire clic_bus_rsp_t bus_rsp,
  input wire clic_int_req_t int_req,
  input wire clic_ctl_t     mintthresh
);

  // Completion in the strobe cycle
  a_cmplt: assert property (@(posedge clic_clk) disable iff (!rst_n)
    bus_rsp.cmplt == bus_req.sel)
    else $error("cmplt differs from sel");

  a_rdata_idle: assert property (@(posedge clic_clk) disable iff (!rst_n)
    !(bus_req.sel && !bus_req.write) |-> bus_rsp.rdata == '0)
    else $error("rdata not zero outside a read");

  // Request was built from the previous cycle's threshold
  a_req_thresh: assert property (@(posedge clic_clk) disable iff (!rst_n)
    int_req.vld |-> int_req.ctl > $past(mintthresh))
    else $error("request level at or below threshold");

endmodule

bind clic_top clic_props i_props (
  .clic_clk   (clic_clk),
  .rst_n      (rst_n),
  .bus_req    (bus_req),
  .bus_rsp    (bus_rsp),
  .int_req    (int_req),
  .mintthresh (mintthresh)
);

`default_nettype wire

// ==== tb/clic_tb.sv ====
// CLIC testbench
`timescale 1ns/1ps
`default_nettype none

`include "clic_defines.svh"

module clic_tb
  import clic_bus_pkg::*;
  import clic_int_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int NUM_INT    = `CLIC_INT_NUM;
  localparam int N_CTRL     = 16;
  localparam int N_LANE     = 64;
  localparam int N_ARB      = 24;
  // Rough count of bus and idle cycles over all sections
  localparam int NUM_OPS    = 16 + N_CTRL * 8 + N_LANE * 2 + NUM_INT * 40
                              + N_ARB * (NUM_INT + 8);

  logic                clic_clk;
  logic                rst_n;
  clic_bus_req_t       bus_req;
  clic_bus_rsp_t       bus_rsp;
  logic [NUM_INT-1:0]  int_src;
  clic_int_req_t       int_req;
  integer              seed;

  // Register mirror
  logic [3:0]          m_nlbits;
  clic_ctl_t           m_thresh;
  logic [NUM_INT-1:0]  m_ip;
  logic [NUM_INT-1:0]  m_ie;
  logic [NUM_INT-1:0]  m_attr;
  logic [NUM_INT-1:0]  m_src;
  logic [NUM_INT-1:0]  m_src_q;
  clic_ctl_t           m_ctl [NUM_INT];

  // Expected values for the compare process
  clic_data_t          exp_rdata;
  clic_int_req_t       exp_req;
  logic                chk_req;

  clic_top i_dut (
    .clic_clk (clic_clk),
    .rst_n    (rst_n),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp),
    .int_src  (int_src),
    .int_req  (int_req)
  );

  always #(CLK_PERIOD / 2) clic_clk = ~clic_clk;

  //==========================================================================
  // Reference model
  //==========================================================================

  // Word layout {ctl, attr, ie, ip}
  function automatic clic_data_t kid_word(input logic ip, input logic ie, input logic attr,
                                          input clic_ctl_t ctl);
    return {ctl, 7'd0, attr, 7'd0, ie, 7'd0, ip};
  endfunction

  function automatic clic_addr_t kid_addr(input int i);
    return `CLICKID_BASE + 16'(4 * i);
  endfunction

  // Interrupt word index or -1 outside the array
  function automatic int kid_index(input clic_addr_t addr);
    if (addr >= `CLICKID_BASE && addr < `CLICKID_BASE + 16'(4 * NUM_INT))
      return int'(addr - `CLICKID_BASE) / 4;
    return -1;
  endfunction

  // Naturally aligned lanes and none for bad pairs
  function automatic logic [3:0] lane_bits(input clic_addr_t addr, input clic_size_t size);
    int         nbytes;
    int         off;
    logic [3:0] lanes;
    nbytes = 1 << size;
    off    = int'(addr[1:0]);
    lanes  = '0;
    if (nbytes <= 4 && off % nbytes == 0)
      for (int k = 0; k < nbytes; k++)
        lanes[off + k] = 1'b1;
    return lanes;
  endfunction

  function automatic clic_data_t ref_read(input clic_addr_t addr);
    int idx;
    idx = kid_index(addr);
    if (addr == `CLICCFG_BASE)
      return {27'd0, m_nlbits, 1'b0};
    if (addr == `CLICINFO_BASE)
      return 32'(`CLIC_INT_NUM);
    if (addr == `MINTTHRESH_BASE)
      return {24'd0, m_thresh};
    if (idx >= 0)
      return kid_word(m_ip[idx], m_ie[idx], m_attr[idx], m_ctl[idx]);
    return '0;
  endfunction

  function automatic logic is_eligible(input int i);
    return m_ip[i] && m_ie[i] && (m_ctl[i] > m_thresh);
  endfunction

  // Expected request from the top level and then its lowest id
  function automatic clic_int_req_t ref_arb();
    clic_int_req_t r;
    int            lvl;
    r   = '0;
    lvl = -1;
    for (int i = 0; i < NUM_INT; i++)
      if (is_eligible(i) && int'(m_ctl[i]) > lvl)
        lvl = int'(m_ctl[i]);
    if (lvl >= 0)
    begin
      r.vld = 1'b1;
      r.ctl = clic_ctl_t'(lvl);
      // Downward scan leaves the lowest id
      for (int i = NUM_INT - 1; i >= 0; i--)
        if (is_eligible(i) && int'(m_ctl[i]) == lvl)
          r.id = clic_id_t'(i);
    end
    return r;
  endfunction

  // Mirror update at one rising edge
  task automatic model_edge(input logic wr, input clic_addr_t addr, input clic_size_t size,
                            input clic_data_t wd);
    logic [3:0]         lanes;
    logic [NUM_INT-1:0] attr_old;
    int                 idx;
    lanes    = lane_bits(addr, size);
    attr_old = m_attr;
    idx      = wr ? kid_index(addr) : -1;
    if (wr && addr == `CLICCFG_BASE)
      m_nlbits = wd[4:1];
    if (wr && addr == `MINTTHRESH_BASE)
      m_thresh = wd[7:0];
    for (int i = 0; i < NUM_INT; i++)
    begin
      // Level tracks the source and an edge rise beats a write
      if (!attr_old[i])
        m_ip[i] = m_src[i];
      else if (m_src[i] && !m_src_q[i])
        m_ip[i] = 1'b1;
      else if (idx == i && lanes[0])
        m_ip[i] = wd[0];
      if (idx == i && lanes[1])
        m_ie[i] = wd[8];
      if (idx == i && lanes[2])
        m_attr[i] = wd[16];
      if (idx == i && lanes[3])
        m_ctl[i] = wd[31:24];
    end
    m_src_q = m_src;
  endtask

  //==========================================================================
  // Checking
  //==========================================================================

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("** Error: %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // rdata and cmplt checked every cycle including writes and idle cycles
  always @(negedge clic_clk)
  begin
    if (rst_n)
    begin
      compare_value("bus_rsp.cmplt", 32'(bus_rsp.cmplt), 32'(bus_req.sel));
      compare_value("bus_rsp.rdata", bus_rsp.rdata, exp_rdata);
      if (chk_req)
        compare_value("int_req", 32'(int_req), 32'(exp_req));
    end
  end

  initial
  begin
    repeat (NUM_OPS * 10) @(posedge clic_clk);
    $display("Timeout: tests did not finish within %0d cycles", NUM_OPS * 10);
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog expired");
  end

  //==========================================================================
  // Bus and source drivers
  //==========================================================================

  // One bus cycle entered 1 ns after a rising edge
  task automatic bus_cycle(input logic sel, input logic wr, input clic_size_t size,
                           input clic_addr_t addr, input clic_data_t wd);
    bus_req.sel   = sel;
    bus_req.write = wr;
    bus_req.size  = size;
    bus_req.addr  = addr;
    bus_req.wdata = wd;
    exp_rdata     = (sel && !wr) ? ref_read(addr) : '0;
    @(posedge clic_clk);
    model_edge(sel && wr, addr, size, wd);
    #1;
  endtask

  task automatic bus_write(input clic_addr_t addr, input clic_size_t size, input clic_data_t wd);
    bus_cycle(1'b1, 1'b1, size, addr, wd);
  endtask

  task automatic bus_read(input clic_addr_t addr);
    bus_cycle(1'b1, 1'b0, 2'd2, addr, '0);
  endtask

  task automatic idle(input int n);
    repeat (n) bus_cycle(1'b0, 1'b0, 2'd0, '0, '0);
  endtask

  task automatic set_src(input int i, input logic v);
    int_src[i] = v;
    m_src[i]   = v;
  endtask

  task automatic set_src_all(input logic [NUM_INT-1:0] v);
    int_src = v;
    m_src   = v;
  endtask

  // Three quiet cycles and then one request check
  task automatic settle_check();
    idle(3);
    exp_req = ref_arb();
    chk_req = 1'b1;
    idle(1);
    chk_req = 1'b0;
  endtask

  //==========================================================================
  // Test sequence
  //==========================================================================

  initial
  begin
    int idx;
    clic_clk  = 1'b0;
    rst_n     = 1'b0;
    bus_req   = '0;
    int_src   = '0;
    seed      = 32'h7780_d358;
    m_nlbits  = '0;
    m_thresh  = '0;
    m_ip      = '0;
    m_ie      = '0;
    m_attr    = '0;
    m_src     = '0;
    m_src_q   = '0;
    exp_rdata = '0;
    exp_req   = '0;
    chk_req   = 1'b0;
    for (int i = 0; i < NUM_INT; i++)
      m_ctl[i] = '0;
    repeat (5) @(posedge clic_clk);
    #1;
    rst_n = 1'b1;

    // Reset values
    bus_read(`CLICCFG_BASE);
    bus_read(`CLICINFO_BASE);
    bus_read(`MINTTHRESH_BASE);
    for (int i = 0; i < NUM_INT; i++)
      bus_read(kid_addr(i));
    settle_check();

    // Control registers and unmapped space
    for (int n = 0; n < N_CTRL; n++)
    begin
      bus_write(`CLICCFG_BASE, 2'd2, $random(seed));
      bus_read(`CLICCFG_BASE);
      bus_write(`CLICINFO_BASE, 2'd2, $random(seed));
      bus_read(`CLICINFO_BASE);
      bus_write(`MINTTHRESH_BASE, 2'd2, $random(seed));
      bus_read(`MINTTHRESH_BASE);
      bus_read(16'($random(seed)) & 16'hfffc);
      bus_read(16'h000c + 16'(4 * n));
    end

    // Random lanes with sizes that include bad pairs
    for (int n = 0; n < N_LANE; n++)
    begin
      idx = int'({$random(seed)} % NUM_INT);
      bus_write(kid_addr(idx) + 16'($random(seed) & 3), 2'($random(seed)), $random(seed));
      bus_read(kid_addr(idx));
    end

    // Trigger modes for one interrupt at a time
    for (int i = 0; i < NUM_INT; i++)
    begin
      bus_write(kid_addr(i), 2'd2, kid_word(1'b0, 1'b0, 1'b0, 8'h00));
      set_src(i, 1'b1);
      idle(3);
      bus_read(kid_addr(i));
      // Level mode ignores ip writes
      bus_write(kid_addr(i), 2'd0, 32'h0);
      bus_read(kid_addr(i));
      set_src(i, 1'b0);
      idle(3);
      bus_write(kid_addr(i), 2'd0, 32'h1);
      bus_read(kid_addr(i));
      // Edge mode through the attr byte
      bus_write(kid_addr(i) + 16'd2, 2'd0, 32'h0001_0000);
      set_src(i, 1'b1);
      idle(3);
      bus_read(kid_addr(i));
      set_src(i, 1'b0);
      idle(3);
      bus_read(kid_addr(i));
      bus_write(kid_addr(i), 2'd0, 32'h0);
      idle(3);
      bus_read(kid_addr(i));
      // Rise and clearing write together
      set_src(i, 1'b1);
      bus_write(kid_addr(i), 2'd0, 32'h0);
      idle(3);
      bus_read(kid_addr(i));
      set_src(i, 1'b0);
      bus_write(kid_addr(i), 2'd2, 32'h0);
    end

    // Arbitration with few levels so ties are common
    for (int n = 0; n < N_ARB; n++)
    begin
      for (int i = 0; i < NUM_INT; i++)
        bus_write(kid_addr(i), 2'd2, kid_word(1'b0, 1'($random(seed)), 1'b0,
                                              8'(({$random(seed)} % 4) * 64 + 16)));
      // Odd rounds put the threshold on a used level
      bus_write(`MINTTHRESH_BASE, 2'd2, 32'(({$random(seed)} % 4) * 64 + 16 * (n % 2)));
      set_src_all(NUM_INT'($random(seed)));
      settle_check();
    end

    idle(2);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== clic.f ====
+incdir+design
design/clic_bus_pkg.sv
design/clic_int_pkg.sv
design/clic_sel.sv
design/clic_busif.sv
design/clic_ctrl.sv
design/clic_kid.sv
design/clic_arb.sv
design/clic_top.sv
tb/clic_props.sv
tb/clic_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CLIC testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
  -f clic.f \
  --top-module clic_tb \
  -Mdir obj_dir -o clic_sim
./obj_dir/clic_sim
